/* all.f */
design/x86_isa_pkg.sv
design/br_types_pkg.sv
design/evaluate_branch.sv
design/flag_unit.sv
design/branch_exec.sv
design/branch_unit_top.sv
verification/branch_unit_chk.sv
verification/branch_unit_tb.sv

/* design/br_types_pkg.sv */
// =========================================================================
// Branch unit data types. Register widths, the flag set and the packed
// request and state structs that pass between the branch unit blocks
// =========================================================================

package br_types_pkg;

	import x86_isa_pkg::*;

	// A 16-bit architectural register value such as IP or CX
	typedef logic [15:0] word_t;

	// Short-branch displacement, a two's complement byte
	typedef logic signed [7:0] disp_t;

	// The five condition flags kept by the core
	// Only the flags read by the short branches are modelled here
	typedef struct packed {
		// Zero, the last result was all zeros
		logic zf;
		// Carry, the subtraction needed a borrow
		logic cf;
		// Sign, copy of the result's top bit
		logic sf;
		// Overflow, the signed result does not fit in 16 bits
		logic vf;
		// Parity, the low result byte has an even count of ones
		logic pf;
	} flags_t;

	// Compare request, the flags come from a minus b
	typedef struct packed {
		word_t a;
		word_t b;
	} cmp_req_t;

	// Branch request, opcode byte followed by its displacement byte
	typedef struct packed {
		opcode_t op;
		disp_t   disp;
	} br_req_t;

	// Architectural state of the branch executor
	typedef struct packed {
		word_t ip;
		word_t cx;
	} br_state_t;

endpackage

/* design/branch_exec.sv */
// =========================================================================
// Short-branch executor. Holds IP and CX, resolves each branch request
// against the flags and advances IP, decrementing CX for the LOOP forms
// =========================================================================

`timescale 1ns/1ns

module branch_exec
	import x86_isa_pkg::*;
	import br_types_pkg::*;
#(
	// Instruction pointer after reset
	parameter word_t RESET_IP = 16'hFFF0
) (
	input  logic      clk,
	input  logic      arst_n,
	input  logic      br_valid,
	input  br_req_t   br_req,
	input  logic      cx_load,
	input  word_t     cx_data,
	input  flags_t    flags,
	output br_state_t state,
	output logic      br_done,
	output logic      br_taken
);

	// Condition result for the opcode currently presented
	logic  take_br;
	// Opcode is one of LOOP, LOOPZ or LOOPNZ
	logic  is_loop;
	// Displacement widened to the register width
	word_t disp_ext;
	// Address of the next sequential instruction
	word_t ip_seq;
	// IP after this branch, taken or not
	word_t ip_next;

	// =====================================================================
	// Condition decode
	// =====================================================================

	// The decoder sees CX and the flags as registered before this edge,
	// so a compare or load in the same cycle cannot steer the branch
	evaluate_branch u_eval (
		.op      (br_req.op),
		.cx      (state.cx),
		.flags   (flags),
		.take_br (take_br)
	);

	// JCXZ is left out on purpose, it tests CX but never writes it
	assign is_loop = (br_req.op == op_loop) ||
	                 (br_req.op == op_loopz) ||
	                 (br_req.op == op_loopnz);

	// =====================================================================
	// Target arithmetic
	// =====================================================================

	// Every short branch is two bytes long, opcode plus displacement
	assign ip_seq   = state.ip + 16'd2;
	assign disp_ext = {{8{br_req.disp[7]}}, br_req.disp};
	// Both sums wrap at 64K like the real segment offset
	assign ip_next  = take_br ? (ip_seq + disp_ext) : ip_seq;

	// =====================================================================
	// Architectural registers
	// =====================================================================

	// Instruction pointer moves only when a branch is executed
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state.ip <= RESET_IP;
		end else if (br_valid) begin
			state.ip <= ip_next;
		end
	end

	// An explicit CX load beats the loop decrement in the same cycle.
	// The decrement happens whether or not the loop is taken
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state.cx <= '0;
		end else if (cx_load) begin
			state.cx <= cx_data;
		end else if (br_valid && is_loop) begin
			state.cx <= state.cx - 16'd1;
		end
	end

	// Completion pulse, one cycle wide, with the taken result beside it
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			br_done  <= 1'b0;
			br_taken <= 1'b0;
		end else begin
			br_done  <= br_valid;
			br_taken <= br_valid & take_br;
		end
	end

endmodule

/* design/branch_unit_top.sv */
// =========================================================================
// Short-branch unit top level. Joins the compare flag unit and the
// branch executor and brings their strobes and state out to the ports
// =========================================================================

`timescale 1ns/1ns

module branch_unit_top
	import br_types_pkg::*;
#(
	// Instruction pointer after reset, handed down to the executor
	parameter word_t RESET_IP = 16'hFFF0
) (
	input  logic      clk,
	input  logic      arst_n,
	// Compare strobe with its two operands
	input  logic      cmp_valid,
	input  cmp_req_t  cmp_req,
	// CX load strobe with the new count
	input  logic      cx_load,
	input  word_t     cx_data,
	// Branch strobe with opcode and displacement
	input  logic      br_valid,
	input  br_req_t   br_req,
	// Registered flags, IP and CX
	output flags_t    flags,
	output br_state_t state,
	// Branch completion and its outcome
	output logic      br_done,
	output logic      br_taken
);

	// =====================================================================
	// Compare path
	// =====================================================================

	// The flag register drives both the output port and the executor
	flag_unit u_flag (
		.clk       (clk),
		.arst_n    (arst_n),
		.cmp_valid (cmp_valid),
		.cmp_req   (cmp_req),
		.flags     (flags)
	);

	// =====================================================================
	// Branch path
	// =====================================================================

	branch_exec #(
		.RESET_IP (RESET_IP)
	) u_exec (
		.clk      (clk),
		.arst_n   (arst_n),
		.br_valid (br_valid),
		.br_req   (br_req),
		.cx_load  (cx_load),
		.cx_data  (cx_data),
		.flags    (flags),
		.state    (state),
		.br_done  (br_done),
		.br_taken (br_taken)
	);

endmodule

/* design/evaluate_branch.sv */
// =========================================================================
// Branch condition decoder. Decides from the opcode, the flags and CX
// whether a short jump or loop instruction is taken
// =========================================================================

`timescale 1ns/1ns

module evaluate_branch
	import x86_isa_pkg::*;
	import br_types_pkg::*;
(
	input  opcode_t op,
	input  word_t   cx,
	input  flags_t  flags,
	output logic    take_br
);

	// CX is one, so a LOOP decrement lands on zero and falls through
	logic cx_one;
	// CX is zero, the JCXZ condition
	logic cx_zero;
	// Signed less-than, sign and overflow disagree
	logic lt;

	assign cx_one  = (cx == 16'h0001);
	assign cx_zero = (cx == 16'h0000);
	assign lt      = flags.sf ^ flags.vf;

	// =====================================================================
	// Condition table
	// =====================================================================
	always_comb begin
		case (op)
			// Unconditional short jump
			op_jmps:   take_br = 1'b1;

			// Single-flag tests, each followed by its inverse
			op_jo:     take_br = flags.vf;
			op_jno:    take_br = ~flags.vf;
			op_jb:     take_br = flags.cf;
			op_jae:    take_br = ~flags.cf;
			op_je:     take_br = flags.zf;
			op_jne:    take_br = ~flags.zf;
			op_js:     take_br = flags.sf;
			op_jns:    take_br = ~flags.sf;
			op_jp:     take_br = flags.pf;
			op_jnp:    take_br = ~flags.pf;

			// Unsigned ordering, below or equal uses borrow and zero
			op_jbe:    take_br = flags.cf | flags.zf;
			op_ja:     take_br = ~(flags.cf | flags.zf);

			// Signed ordering built on the sign/overflow mismatch
			op_jl:     take_br = lt;
			op_jnl:    take_br = ~lt;
			op_jle:    take_br = lt | flags.zf;
			op_jnle:   take_br = ~(lt | flags.zf);

			// Count-register forms. CX here is the value before the
			// decrement, so "not one" means nonzero after it
			op_jcxz:   take_br = cx_zero;
			op_loop:   take_br = ~cx_one;
			op_loopz:  take_br = ~cx_one & flags.zf;
			op_loopnz: take_br = ~cx_one & ~flags.zf;

			// Anything else is not a branch this unit knows about
			default:   take_br = 1'b0;
		endcase
	end

endmodule

/* design/flag_unit.sv */
// =========================================================================
// Compare flag unit. Subtracts the two compare operands and keeps the
// resulting zero, carry, sign, overflow and parity flags in a register
// =========================================================================

`timescale 1ns/1ns

module flag_unit
	import br_types_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,
	input  logic     cmp_valid,
	input  cmp_req_t cmp_req,
	output flags_t   flags
);

	// Difference with one extra bit on top to catch the borrow
	logic [16:0] diff;
	// The 16-bit result as the ALU would write it
	word_t       res;
	// Flags derived from the current operands
	flags_t      cmp_flags;

	// =====================================================================
	// Subtraction and flag derivation
	// =====================================================================

	// Both operands are zero-extended, so bit 16 is set exactly when
	// a is below b as unsigned numbers
	assign diff = {1'b0, cmp_req.a} - {1'b0, cmp_req.b};
	assign res  = diff[15:0];

	always_comb begin
		cmp_flags.zf = (res == 16'h0000);
		cmp_flags.cf = diff[16];
		cmp_flags.sf = res[15];
		// Subtracting operands of unlike sign can overflow, and it did
		// when the result sign no longer matches the minuend
		cmp_flags.vf = (cmp_req.a[15] ^ cmp_req.b[15]) & (res[15] ^ cmp_req.a[15]);
		// Parity only looks at the low byte, set for an even count
		cmp_flags.pf = ~^res[7:0];
	end

	// =====================================================================
	// Flag register
	// =====================================================================

	// New flags appear one cycle after the compare strobe and then hold
	// until the next compare
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			flags <= '0;
		end else if (cmp_valid) begin
			flags <= cmp_flags;
		end
	end

endmodule

/* design/x86_isa_pkg.sv */
// =========================================================================
// x86 short-branch opcodes. Opcode byte type and the named constants for
// the short conditional jumps, JMPS, JCXZ and the three LOOP forms
// =========================================================================

package x86_isa_pkg;

	// First byte of an instruction as it leaves the decoder
	typedef logic [7:0] opcode_t;

	// Unconditional short jump with an 8-bit displacement
	localparam opcode_t op_jmps   = 8'hEB;

	// =====================================================================
	// Conditional short jumps, 70 to 7F
	// =====================================================================
	// Each even opcode tests a condition and the following odd opcode
	// tests its inverse. The aliases used by assemblers share the codes
	// (JC and JNAE are JB, JG is JNLE and so on)
	localparam opcode_t op_jo     = 8'h70;
	localparam opcode_t op_jno    = 8'h71;
	localparam opcode_t op_jb     = 8'h72;
	localparam opcode_t op_jae    = 8'h73;
	localparam opcode_t op_je     = 8'h74;
	localparam opcode_t op_jne    = 8'h75;
	localparam opcode_t op_jbe    = 8'h76;
	localparam opcode_t op_ja     = 8'h77;
	localparam opcode_t op_js     = 8'h78;
	localparam opcode_t op_jns    = 8'h79;
	localparam opcode_t op_jp     = 8'h7A;
	localparam opcode_t op_jnp    = 8'h7B;
	localparam opcode_t op_jl     = 8'h7C;
	localparam opcode_t op_jnl    = 8'h7D;
	localparam opcode_t op_jle    = 8'h7E;
	localparam opcode_t op_jnle   = 8'h7F;

	// =====================================================================
	// Count-register branches, E0 to E3
	// =====================================================================
	// The LOOP forms decrement CX before the test, JCXZ only reads it
	localparam opcode_t op_loopnz = 8'hE0;
	localparam opcode_t op_loopz  = 8'hE1;
	localparam opcode_t op_loop   = 8'hE2;
	localparam opcode_t op_jcxz   = 8'hE3;

endpackage

/* run.sh */
#!/bin/sh
# Build the branch unit testbench with Verilator, run it and decide the
# result from the pass line in the simulation log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module branch_unit_tb -f all.f \
	-o branch_unit_sim &&
	./obj_dir/branch_unit_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TEST PASS" sim.log && echo "simulation passed" ||
	{ echo "simulation failed, see sim.log"; exit 1; }

/* verification/branch_unit_chk.sv */
// =========================================================================
// Branch executor checker. Concurrent assertions on the completion pulse
// and on the pointer step of branches that fall through
// =========================================================================

`timescale 1ns/1ns

module branch_unit_chk
	import br_types_pkg::*;
(
	input logic      clk,
	input logic      arst_n,
	input logic      br_valid,
	input logic      br_done,
	input logic      br_taken,
	input br_state_t state
);

	// Count of failed assertions so far
	int fail_count = 0;

	// =====================================================================
	// Completion pulse timing
	// =====================================================================

	// A branch strobe is answered on the very next cycle
	done_after_valid: assert property (
		@(posedge clk) disable iff (!arst_n)
		br_valid |=> br_done
	) else begin
		fail_count = fail_count + 1;
		$error("br_done did not follow br_valid by one cycle");
	end

	// Without a strobe there is nothing to complete, so the pulse
	// cannot stretch past its one cycle
	no_done_without_valid: assert property (
		@(posedge clk) disable iff (!arst_n)
		!br_valid |=> !br_done
	) else begin
		fail_count = fail_count + 1;
		$error("br_done high without a branch in the cycle before");
	end

	// The taken flag only has a meaning beside a completion
	taken_needs_done: assert property (
		@(posedge clk) disable iff (!arst_n)
		br_taken |-> br_done
	) else begin
		fail_count = fail_count + 1;
		$error("br_taken high while br_done is low");
	end

	// =====================================================================
	// Pointer arithmetic
	// =====================================================================

	// A branch that falls through only steps over its two bytes.
	// The sum wraps at 64K, hence the cast back to the word width
	ip_step_not_taken: assert property (
		@(posedge clk) disable iff (!arst_n)
		(br_done && !br_taken) |-> (state.ip == word_t'($past(state.ip) + 16'd2))
	) else begin
		fail_count = fail_count + 1;
		$error("IP after a not-taken branch is not the old IP plus 2");
	end

endmodule

// Attach the checker to every branch executor in the design
bind branch_exec branch_unit_chk u_chk (
	.clk      (clk),
	.arst_n   (arst_n),
	.br_valid (br_valid),
	.br_done  (br_done),
	.br_taken (br_taken),
	.state    (state)
);

/* verification/branch_unit_tb.sv */
// =========================================================================
// Branch unit testbench. Drives compares, CX loads and short branches and
// checks flags, IP, CX and the completion outputs against a model
// =========================================================================

`timescale 1ns/1ns

module branch_unit_tb
	import x86_isa_pkg::*;
	import br_types_pkg::*;
();

	logic      clk = 1'b0;
	logic      arst_n;
	logic      cmp_valid;
	cmp_req_t  cmp_req;
	logic      cx_load;
	word_t     cx_data;
	logic      br_valid;
	br_req_t   br_req;
	flags_t    flags;
	br_state_t state;
	logic      br_done;
	logic      br_taken;

	// Model of the architectural state and of the expected outputs
	word_t  m_ip;
	word_t  m_cx;
	flags_t m_flags;
	logic   m_done;
	logic   m_taken;

	integer      seed;
	logic [31:0] rnd;
	integer      i;
	integer      j;
	integer      k;
	opcode_t     op;

	// Operand pairs that reach the corner flag combinations
	word_t   corner_a [6] = '{16'h1234, 16'h0000, 16'h7FFF, 16'h8000, 16'h0005, 16'h0003};
	word_t   corner_b [6] = '{16'h1234, 16'hFFFF, 16'hFFFF, 16'h0001, 16'h0003, 16'h0005};
	opcode_t count_ops [4] = '{op_loop, op_loopz, op_loopnz, op_jcxz};

	branch_unit_top UUT (
		.clk       (clk),
		.arst_n    (arst_n),
		.cmp_valid (cmp_valid),
		.cmp_req   (cmp_req),
		.cx_load   (cx_load),
		.cx_data   (cx_data),
		.br_valid  (br_valid),
		.br_req    (br_req),
		.flags     (flags),
		.state     (state),
		.br_done   (br_done),
		.br_taken  (br_taken)
	);

	// 40 ns period
	always #20 clk = ~clk;

	// =====================================================================
	// Reference model
	// =====================================================================

	// Flags from a minus b, worked out on full-width integers
	function automatic flags_t compare_model(word_t a, word_t b);
		flags_t f;
		word_t  r;
		integer sa;
		integer sb;
		integer sd;
		integer ones;
		integer n;
		r = a - b;
		sa = {{16{a[15]}}, a};
		sb = {{16{b[15]}}, b};
		sd = sa - sb;
		ones = 0;
		for (n = 0; n < 8; n++) begin
			if (r[n])
				ones = ones + 1;
		end
		f.zf = (a == b);
		f.cf = (a < b);
		f.sf = r[15];
		f.vf = (sd > 32767) || (sd < -32768);
		f.pf = (ones % 2 == 0);
		return f;
	endfunction

	// Taken decision. Bits 3:1 of a 7x opcode pick the test, bit 0 inverts it
	function automatic logic branch_model(opcode_t opc, word_t cx, flags_t f);
		logic  cond;
		word_t cx_after;
		cx_after = cx - 16'd1;
		if (opc[7:4] == 4'h7) begin
			case (opc[3:1])
				3'd0: cond = f.vf;
				3'd1: cond = f.cf;
				3'd2: cond = f.zf;
				3'd3: cond = f.cf | f.zf;
				3'd4: cond = f.sf;
				3'd5: cond = f.pf;
				3'd6: cond = (f.sf != f.vf);
				default: cond = (f.sf != f.vf) | f.zf;
			endcase
			return cond ^ opc[0];
		end
		case (opc)
			op_jmps:   return 1'b1;
			op_jcxz:   return (cx == 16'h0000);
			op_loop:   return (cx_after != 16'h0000);
			op_loopz:  return (cx_after != 16'h0000) && f.zf;
			op_loopnz: return (cx_after != 16'h0000) && !f.zf;
			default:   return 1'b0;
		endcase
	endfunction

	function automatic logic is_branch_op(opcode_t opc);
		return (opc[7:4] == 4'h7) || (opc == op_jmps) || (opc[7:2] == 6'b111000);
	endfunction

	// =====================================================================
	// Checks and stimulus
	// =====================================================================

	task automatic fail_run();
		$display("TEST FAIL");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_outputs();
		assert (state.ip == m_ip) else begin
			$display("mismatch state.ip: dut %h model %h", state.ip, m_ip);
			fail_run();
		end
		assert (state.cx == m_cx) else begin
			$display("mismatch state.cx: dut %h model %h", state.cx, m_cx);
			fail_run();
		end
		assert (flags == m_flags) else begin
			$display("mismatch flags: dut %h model %h", flags, m_flags);
			fail_run();
		end
		assert (br_done == m_done) else begin
			$display("mismatch br_done: dut %h model %h", br_done, m_done);
			fail_run();
		end
		assert (br_taken == m_taken) else begin
			$display("mismatch br_taken: dut %h model %h", br_taken, m_taken);
			fail_run();
		end
		// The bound checker counts its own failures on the executor
		assert (UUT.u_exec.u_chk.fail_count == 0) else begin
			$display("the bound checker flagged a concurrent assertion failure");
			fail_run();
		end
	endtask

	// One request of any mix of strobes, then the model step and the checks
	task automatic run_cycle(input logic cmp_v, input word_t a, input word_t b,
	                         input logic cxl, input word_t cxd,
	                         input logic brv, input opcode_t opc, input disp_t disp);
		integer waited;
		logic   take;
		word_t  disp_ext;
		@(posedge clk);
		cmp_valid  <= cmp_v;
		cmp_req.a  <= a;
		cmp_req.b  <= b;
		cx_load    <= cxl;
		cx_data    <= cxd;
		br_valid   <= brv;
		br_req.op  <= opc;
		br_req.disp <= disp;
		// The model steps from the state held before the sampling edge
		take = brv && branch_model(opc, m_cx, m_flags);
		disp_ext = {{8{disp[7]}}, disp};
		m_done = brv;
		m_taken = take;
		if (brv)
			m_ip = m_ip + 16'd2 + (take ? disp_ext : 16'h0000);
		if (cxl)
			m_cx = cxd;
		else if (brv && (opc == op_loop || opc == op_loopz || opc == op_loopnz))
			m_cx = m_cx - 16'd1;
		if (cmp_v)
			m_flags = compare_model(a, b);
		@(posedge clk);
		cmp_valid <= 1'b0;
		cx_load   <= 1'b0;
		br_valid  <= 1'b0;
		waited = 0;
		@(negedge clk);
		while (brv && !br_done && waited < 8) begin
			@(negedge clk);
			waited++;
		end
		if (brv && !br_done) begin
			$display("br_done never arrived within 8 cycles of a branch request");
			fail_run();
		end
		check_outputs();
	endtask

	task automatic compare_pair(input word_t a, input word_t b);
		run_cycle(1'b1, a, b, 1'b0, 16'h0000, 1'b0, 8'h00, 8'sh00);
	endtask

	task automatic load_cx(input word_t v);
		run_cycle(1'b0, 16'h0000, 16'h0000, 1'b1, v, 1'b0, 8'h00, 8'sh00);
	endtask

	task automatic issue_branch(input opcode_t opc, input disp_t disp);
		run_cycle(1'b0, 16'h0000, 16'h0000, 1'b0, 16'h0000, 1'b1, opc, disp);
	endtask

	initial begin
		seed = 32'h13df_947c;
		arst_n = 1'b0;
		cmp_valid = 1'b0;
		cmp_req = '0;
		cx_load = 1'b0;
		cx_data = '0;
		br_valid = 1'b0;
		br_req = '0;
		m_ip = 16'hFFF0;
		m_cx = 16'h0000;
		m_flags = '0;
		m_done = 1'b0;
		m_taken = 1'b0;

		// Reset for two cycles, then the reset values must show
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		check_outputs();

		// Compare flags on the corner pairs and on random pairs
		for (i = 0; i < 6; i++)
			compare_pair(corner_a[i], corner_b[i]);
		for (i = 0; i < 40; i++) begin
			rnd = $random(seed);
			compare_pair(rnd[15:0], rnd[31:16]);
		end

		// Every conditional jump after each flag setting, IP wraps on the way
		for (k = 0; k < 14; k++) begin
			rnd = $random(seed);
			if (k < 6)
				compare_pair(corner_a[k], corner_b[k]);
			else
				compare_pair(rnd[15:0], rnd[31:16]);
			for (j = 0; j < 16; j++) begin
				rnd = $random(seed);
				issue_branch(8'h70 + j[7:0], rnd[7:0]);
			end
		end

		// Count-register forms with CX at 0, 1 and 2 and zf both ways
		for (i = 0; i < 4; i++) begin
			for (j = 0; j < 3; j++) begin
				for (k = 0; k < 2; k++) begin
					load_cx(j[15:0]);
					compare_pair(16'h0005, (k == 0) ? 16'h0005 : 16'h0003);
					rnd = $random(seed);
					issue_branch(count_ops[i], rnd[7:0]);
				end
			end
		end
		// A load beside a loop overrides the decrement
		load_cx(16'h0003);
		run_cycle(1'b0, 16'h0000, 16'h0000, 1'b1, 16'h55AA, 1'b1, op_loop, 8'shF0);
		run_cycle(1'b0, 16'h0000, 16'h0000, 1'b1, 16'h0001, 1'b1, op_loopnz, 8'sh10);

		// JMPS at the displacement extremes and at random
		issue_branch(op_jmps, 8'sh7F);
		issue_branch(op_jmps, -8'sd128);
		issue_branch(op_jmps, 8'sh00);
		for (i = 0; i < 8; i++) begin
			rnd = $random(seed);
			issue_branch(op_jmps, rnd[7:0]);
		end
		// Opcodes outside the branch set fall through
		for (i = 0; i < 30; i++) begin
			rnd = $random(seed);
			op = is_branch_op(rnd[7:0]) ? 8'h90 : rnd[7:0];
			issue_branch(op, rnd[15:8]);
		end

		// Compare beside a branch, the branch still sees the old flags
		compare_pair(16'h0005, 16'h0003);
		run_cycle(1'b1, 16'h0007, 16'h0007, 1'b0, 16'h0000, 1'b1, op_je, 8'sh20);
		run_cycle(1'b1, 16'h0001, 16'h0002, 1'b0, 16'h0000, 1'b1, op_jne, 8'sh20);
		for (i = 0; i < 16; i++) begin
			rnd = $random(seed);
			run_cycle(1'b1, rnd[15:0], rnd[31:16], 1'b0, 16'h0000, 1'b1,
			          8'h70 + i[7:0], rnd[23:16]);
		end

		// One more edge so the checker also judges the last completion
		@(posedge clk);
		@(negedge clk);
		if (UUT.u_exec.u_chk.fail_count == 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			$display("the bound checker flagged a concurrent assertion failure");
			fail_run();
		end
	end

endmodule
